// ==== src/ebus_consts.svh ====
`ifndef EBUS_CONSTS_SVH
`define EBUS_CONSTS_SVH

// EBUS word and its halves
`define EBUS_WIDTH 36
`define HALF_WIDTH 18
`define FUNC_WIDTH 7

// bus sources and the register file inside each one
`define NUM_SOURCES 4
`define SRC_REGS 4

// APB port widths
`define APB_ADDR_WIDTH 12
`define APB_DATA_WIDTH 32

// APB register map
`define ADDR_DIAG 12'h000
`define ADDR_EXT 12'h004
`define ADDR_EBUS_LO 12'h008
`define ADDR_EBUS_HI 12'h00C

// source n, register r lives at ADDR_SRC_BASE + n*SRC_STRIDE + 4*r
`define ADDR_SRC_BASE 12'h100
`define SRC_STRIDE 12'h020

// bits of an EBUS word that do not fit in one APB data word
`define EXT_WIDTH (`EBUS_WIDTH - `APB_DATA_WIDTH)

`endif

// ==== src/ebusPkg.sv ====
`include "ebus_consts.svh"

// types shared by everything that sits on the EBUS
package ebusPkg;

  // full 36-bit diagnostic bus word
  typedef logic [`EBUS_WIDTH-1:0] ebusWordT;

  // half-word payload, used by sources that only carry 18 bits
  typedef logic [`HALF_WIDTH-1:0] ebusHalfT;

  // diagnostic function code written by the host
  typedef logic [`FUNC_WIDTH-1:0] diagFuncT;

  // selects one register inside a source unit
  typedef logic [$clog2(`SRC_REGS)-1:0] srcRegIdxT;

  // one bit per source, used for write enables and driving flags
  typedef logic [`NUM_SOURCES-1:0] srcMaskT;

  // index of a source unit
  typedef logic [$clog2(`NUM_SOURCES)-1:0] srcIdxT;

  // extension bits that sit above the APB data word
  typedef logic [`EXT_WIDTH-1:0] ebusExtT;

endpackage

// ==== src/apbPkg.sv ====
`include "ebus_consts.svh"

// types that describe the APB side of the diagnostic port
package apbPkg;

  typedef logic [`APB_ADDR_WIDTH-1:0] apbAddrT;

  typedef logic [`APB_DATA_WIDTH-1:0] apbDataT;

  // decoded register behind an APB address
  typedef enum logic [2:0] {
    regNone,
    regDiag,
    regExt,
    regEbusLo,
    regEbusHi,
    regSrc
  } apbRegT;

  // byte offset inside one source window
  typedef logic [$clog2(`SRC_STRIDE)-1:0] apbSrcOffT;

endpackage

// ==== src/apbEbusPort.sv ====
`timescale 1ns/1ps
`include "ebus_consts.svh"

module apbEbusPort import ebusPkg::*, apbPkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      PSEL,
  input  logic      PENABLE,
  input  logic      PWRITE,
  input  apbAddrT   PADDR,
  input  apbDataT   PWDATA,
  input  ebusWordT  ebusQ,
  output apbDataT   PRDATA,
  output logic      PREADY,
  output logic      PSLVERR,
  output diagFuncT  diagFunc,
  output srcMaskT   srcWrEn,
  output srcRegIdxT wrReg,
  output ebusWordT  wrWord
);

  localparam int STRIDE_BITS = $clog2(`SRC_STRIDE);
  localparam int WIN_END = `ADDR_SRC_BASE + `NUM_SOURCES * `SRC_STRIDE;

  apbRegT    regSel;
  apbAddrT   srcAddr;
  apbSrcOffT srcOff;
  srcIdxT    srcIdx;
  logic      access;
  logic      badDir;
  logic      err;
  diagFuncT  diagQ;
  ebusExtT   extQ;
  ebusExtT   hiHold;

  assign access = PSEL && PENABLE;

  // position inside the source window, split into source and register fields
  assign srcAddr = PADDR - `ADDR_SRC_BASE;
  assign srcOff = srcAddr[STRIDE_BITS-1:0];
  assign srcIdx = srcAddr[STRIDE_BITS +: $bits(srcIdxT)];
  assign wrReg = srcOff[2 +: $bits(srcRegIdxT)];

  always_comb begin
    regSel = regNone;
    if (PADDR == `ADDR_DIAG) regSel = regDiag;
    else if (PADDR == `ADDR_EXT) regSel = regExt;
    else if (PADDR == `ADDR_EBUS_LO) regSel = regEbusLo;
    else if (PADDR == `ADDR_EBUS_HI) regSel = regEbusHi;
    else if (PADDR >= `ADDR_SRC_BASE && int'(PADDR) < WIN_END &&
             int'(srcOff) < 4 * `SRC_REGS && srcOff[1:0] == 2'b00)
      regSel = regSrc;
  end

  // readback registers cannot be written, everything else cannot be read
  assign badDir = PWRITE ? (regSel == regEbusLo || regSel == regEbusHi)
                         : (regSel == regDiag || regSel == regExt || regSel == regSrc);
  assign err = (regSel == regNone) || badDir;

  // zero wait states, so every access phase completes at once
  assign PREADY = access;
  assign PSLVERR = access && err;

  always_comb begin
    PRDATA = '0;
    if (access && !PWRITE) begin
      if (regSel == regEbusLo) PRDATA = ebusQ[`APB_DATA_WIDTH-1:0];
      else if (regSel == regEbusHi) PRDATA = apbDataT'(hiHold);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      diagQ <= '0;
      extQ <= '0;
      hiHold <= '0;
    end else if (access && !err) begin
      if (PWRITE && regSel == regDiag) diagQ <= diagFuncT'(PWDATA);
      if (PWRITE && regSel == regExt) extQ <= ebusExtT'(PWDATA);
      // the low-half read freezes the matching high bits for a later read
      if (!PWRITE && regSel == regEbusLo) hiHold <= ebusQ[`EBUS_WIDTH-1:`APB_DATA_WIDTH];
    end
  end

  assign diagFunc = diagQ;
  assign wrWord = {extQ, PWDATA};
  assign srcWrEn = (access && PWRITE && regSel == regSrc) ? srcMaskT'(1) << srcIdx : '0;

endmodule

// ==== src/ebusSource.sv ====
`timescale 1ns/1ps
`include "ebus_consts.svh"

module ebusSource import ebusPkg::*; #(
  parameter type payloadT = ebusWordT,
  parameter int FUNC_BASE = 0,
  parameter int FUNC_SPAN = 16
) (
  input  logic      clk,
  input  logic      rst,
  input  diagFuncT  diagFunc,
  input  logic      wrEn,
  input  srcRegIdxT wrReg,
  input  ebusWordT  wrWord,
  output logic      driving,
  output ebusWordT  data
);

  localparam int FUNC_END = FUNC_BASE + FUNC_SPAN;

  payloadT   regs [`SRC_REGS];
  srcRegIdxT rdReg;

  // host writes keep only the low bits that fit this unit's payload
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `SRC_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrReg] <= payloadT'(wrWord);
    end
  end

  // this unit owns the bus for its own range of function codes
  assign driving = (int'(diagFunc) >= FUNC_BASE) && (int'(diagFunc) < FUNC_END);

  // the low two bits of the function code pick the register
  assign rdReg = diagFunc[$bits(srcRegIdxT)-1:0];

  always_comb begin
    data = '0;
    if (driving) data = ebusWordT'(regs[rdReg]);
  end

endmodule

// ==== src/ebusMux.sv ====
`timescale 1ns/1ps

module ebusMux import ebusPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  srcMaskT  driving,
  input  ebusWordT srcData0,
  input  ebusWordT srcData1,
  input  ebusWordT srcData2,
  input  ebusWordT srcData3,
  output ebusWordT ebusQ
);

  ebusWordT ebusNext;

  // source 0 has the highest priority, an idle bus reads as zero
  always_comb begin
    if (driving[0])
      ebusNext = srcData0;
    else if (driving[1])
      ebusNext = srcData1;
    else if (driving[2])
      ebusNext = srcData2;
    else if (driving[3])
      ebusNext = srcData3;
    else
      ebusNext = '0;
  end

  // one register stage between the sources and the readback path
  always_ff @(posedge clk) begin
    if (rst)
      ebusQ <= '0;
    else
      ebusQ <= ebusNext;
  end

endmodule

// ==== src/ebusTop.sv ====
`timescale 1ns/1ps
`include "ebus_consts.svh"

module ebusTop import ebusPkg::*, apbPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    PSEL,
  input  logic    PENABLE,
  input  logic    PWRITE,
  input  apbAddrT PADDR,
  input  apbDataT PWDATA,
  output apbDataT PRDATA,
  output logic    PREADY,
  output logic    PSLVERR
);

  diagFuncT  diagFunc;
  srcMaskT   srcWrEn;
  srcRegIdxT wrReg;
  ebusWordT  wrWord;
  srcMaskT   srcDriving;
  ebusWordT  srcData [`NUM_SOURCES];
  ebusWordT  ebusQ;

  apbEbusPort u_port (
    .clk, .rst, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .ebusQ,
    .PRDATA, .PREADY, .PSLVERR, .diagFunc, .srcWrEn, .wrReg, .wrWord
  );

  // APR and CON overlap on codes 08..0F and APR wins by priority
  ebusSource #(.payloadT(ebusWordT), .FUNC_BASE('h00), .FUNC_SPAN(16)) u_apr (
    .clk, .rst, .diagFunc, .wrEn(srcWrEn[0]), .wrReg, .wrWord,
    .driving(srcDriving[0]), .data(srcData[0])
  );

  ebusSource #(.payloadT(ebusWordT), .FUNC_BASE('h08), .FUNC_SPAN(16)) u_con (
    .clk, .rst, .diagFunc, .wrEn(srcWrEn[1]), .wrReg, .wrWord,
    .driving(srcDriving[1]), .data(srcData[1])
  );

  // PI only carries a half word
  ebusSource #(.payloadT(ebusHalfT), .FUNC_BASE('h20), .FUNC_SPAN(8)) u_pi (
    .clk, .rst, .diagFunc, .wrEn(srcWrEn[2]), .wrReg, .wrWord,
    .driving(srcDriving[2]), .data(srcData[2])
  );

  ebusSource #(.payloadT(ebusWordT), .FUNC_BASE('h30), .FUNC_SPAN(8)) u_mtr (
    .clk, .rst, .diagFunc, .wrEn(srcWrEn[3]), .wrReg, .wrWord,
    .driving(srcDriving[3]), .data(srcData[3])
  );

  ebusMux u_mux (
    .clk, .rst, .driving(srcDriving),
    .srcData0(srcData[0]), .srcData1(srcData[1]),
    .srcData2(srcData[2]), .srcData3(srcData[3]),
    .ebusQ
  );

endmodule

// ==== tests/tbClock.sv ====
`timescale 1ns/1ps

// free-running clock for the testbench
module tbClock #(
  parameter real PERIOD_NS = 40.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule

// ==== tests/ebusTop_chk.sv ====
`timescale 1ns/1ps

module ebusTop_chk import ebusPkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     PSEL,
  input logic     PENABLE,
  input logic     PREADY,
  input logic     PSLVERR,
  input srcMaskT  srcWrEn,
  input srcMaskT  srcDriving,
  input ebusWordT ebusQ
);

  // number of failed properties so far
  int errCount = 0;

  accessReady: assert property (@(posedge clk) disable iff (rst)
    (PSEL && PENABLE) |-> PREADY) else begin
    $error("PREADY low in an APB access phase");
    errCount++;
  end

  errWithReady: assert property (@(posedge clk) disable iff (rst)
    PSLVERR |-> PREADY) else begin
    $error("PSLVERR raised without PREADY");
    errCount++;
  end

  oneWriteEnable: assert property (@(posedge clk) disable iff (rst)
    $onehot0(srcWrEn)) else begin
    $error("more than one source write enable set");
    errCount++;
  end

  // an idle bus must read as zero on the next cycle
  idleBusZero: assert property (@(posedge clk) disable iff (rst)
    (srcDriving == '0) |=> (ebusQ == '0)) else begin
    $error("EBUS word not zero after a cycle with no driver");
    errCount++;
  end

endmodule

bind ebusTop ebusTop_chk u_chk (
  .clk, .rst, .PSEL, .PENABLE, .PREADY, .PSLVERR, .srcWrEn, .srcDriving, .ebusQ
);

// ==== tests/ebusTop_tb.sv ====
`timescale 1ns/1ps
`include "ebus_consts.svh"

module ebusTop_tb import ebusPkg::*, apbPkg::*; ();

  // the tests need about 2000 cycles
  localparam int MAX_CYCLES = 4000;

  logic    clk;
  logic    rst;
  logic    PSEL;
  logic    PENABLE;
  logic    PWRITE;
  apbAddrT PADDR;
  apbDataT PWDATA;
  apbDataT PRDATA;
  logic    PREADY;
  logic    PSLVERR;

  // model of the host-visible state
  diagFuncT diagM;
  ebusExtT  extM;
  ebusExtT  hiHoldM;
  ebusWordT regsM [`NUM_SOURCES * `SRC_REGS];

  // one entry per transfer that the comparing process takes in the access phase
  logic    expRead [$];
  logic    expErr [$];
  apbDataT expData [$];
  apbAddrT expAddr [$];
  logic    rdE;
  logic    errE;
  apbDataT dataE;
  apbAddrT addrE;
  int      cycleCount = 0;

  tbClock #(.PERIOD_NS(40.0)) u_clock (.clk);

  ebusTop u_ebusTop (
    .clk, .rst, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PRDATA, .PREADY, .PSLVERR
  );

  task automatic abortRun();
    $display("TB FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  function automatic apbAddrT srcAddr(int n, int r);
    return apbAddrT'(`ADDR_SRC_BASE + n * `SRC_STRIDE + 4 * r);
  endfunction

  // flat model index of a source register address or -1 when none matches
  function automatic int srcSlot(apbAddrT addr);
    int slot;
    slot = -1;
    for (int n = 0; n < `NUM_SOURCES; n++)
      for (int r = 0; r < `SRC_REGS; r++)
        if (addr == srcAddr(n, r)) slot = n * `SRC_REGS + r;
    return slot;
  endfunction

  function automatic logic accessError(logic write, apbAddrT addr);
    if (addr == `ADDR_EBUS_LO || addr == `ADDR_EBUS_HI) return write;
    if (addr == `ADDR_DIAG || addr == `ADDR_EXT || srcSlot(addr) >= 0) return !write;
    return 1'b1;
  endfunction

  // APR wins over CON on codes 08..0F and PI keeps only 18 bits
  function automatic ebusWordT expectedEbus(diagFuncT func);
    int code;
    int r;
    code = int'(func);
    r = code % `SRC_REGS;
    if (code < 'h10) return regsM[r];
    if (code < 'h18) return regsM[`SRC_REGS + r];
    if (code >= 'h20 && code < 'h28)
      return ebusWordT'(regsM[2 * `SRC_REGS + r][`HALF_WIDTH-1:0]);
    if (code >= 'h30 && code < 'h38) return regsM[3 * `SRC_REGS + r];
    return '0;
  endfunction

  function automatic ebusWordT randomWord();
    ebusExtT ext;
    apbDataT low;
    ext = ebusExtT'($urandom());
    low = $urandom();
    return {ext, low};
  endfunction

  task automatic apbTransfer(logic write, apbAddrT addr, apbDataT data);
    logic     err;
    int       slot;
    ebusWordT word;
    err = accessError(write, addr);
    slot = srcSlot(addr);
    word = expectedEbus(diagM);
    expRead.push_back(!write);
    expErr.push_back(err);
    expAddr.push_back(addr);
    if (addr == `ADDR_EBUS_HI) expData.push_back(apbDataT'(hiHoldM));
    else expData.push_back(word[`APB_DATA_WIDTH-1:0]);
    @(posedge clk);
    PSEL <= 1'b1;
    PENABLE <= 1'b0;
    PWRITE <= write;
    PADDR <= addr;
    PWDATA <= data;
    @(posedge clk);
    PENABLE <= 1'b1;
    @(posedge clk);
    PSEL <= 1'b0;
    PENABLE <= 1'b0;
    // a rejected transfer leaves the model alone
    if (!err) begin
      if (!write && addr == `ADDR_EBUS_LO) hiHoldM = word[`EBUS_WIDTH-1:`APB_DATA_WIDTH];
      if (write && addr == `ADDR_DIAG) diagM = diagFuncT'(data);
      if (write && addr == `ADDR_EXT) extM = ebusExtT'(data);
      if (write && slot >= 0) regsM[slot] = {extM, data};
    end
  endtask

  // the extra idle cycle gives a later read two idle cycles
  task automatic apbWrite(apbAddrT addr, apbDataT data);
    apbTransfer(1'b1, addr, data);
    @(posedge clk);
  endtask

  task automatic apbRead(apbAddrT addr);
    apbTransfer(1'b0, addr, $urandom());
  endtask

  task automatic loadReg(int n, int r, ebusWordT word);
    apbWrite(`ADDR_EXT, apbDataT'(word[`EBUS_WIDTH-1:`APB_DATA_WIDTH]));
    apbWrite(srcAddr(n, r), word[`APB_DATA_WIDTH-1:0]);
  endtask

  task automatic checkCode(int code);
    apbWrite(`ADDR_DIAG, apbDataT'(code));
    apbRead(`ADDR_EBUS_LO);
    apbRead(`ADDR_EBUS_HI);
  endtask

  always @(negedge clk) begin
    assert (u_ebusTop.u_chk.errCount == 0) else begin
      $display("bus checker assertion failed before %0t ns", $time);
      abortRun();
    end
    if (!rst && PSEL && PENABLE) begin
      assert (expErr.size() > 0) else begin
        $display("access phase at %0t ns with no transfer expected", $time);
        abortRun();
      end
      rdE = expRead.pop_front();
      errE = expErr.pop_front();
      dataE = expData.pop_front();
      addrE = expAddr.pop_front();
      assert (PREADY === 1'b1) else begin
        $display("PREADY stayed low in the access phase at %0t ns", $time);
        abortRun();
      end
      assert (PSLVERR === errE) else begin
        $display("MISMATCH at %0t ns: PSLVERR %b at address %h, expected %b",
                 $time, PSLVERR, addrE, errE);
        abortRun();
      end
      if (rdE && !errE) begin
        assert (PRDATA === dataE) else begin
          $display("MISMATCH at %0t ns: PRDATA %h from address %h, expected %h",
                   $time, PRDATA, addrE, dataE);
          abortRun();
        end
      end
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= MAX_CYCLES) begin
      $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
      abortRun();
    end
  end

  initial begin
    apbAddrT addr;
    void'($urandom(5));
    rst <= 1'b1;
    PSEL <= 1'b0;
    PENABLE <= 1'b0;
    PWRITE <= 1'b0;
    PADDR <= '0;
    PWDATA <= '0;
    diagM = '0;
    extM = '0;
    hiHoldM = '0;
    foreach (regsM[i]) regsM[i] = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    // everything reads as zero after reset
    apbRead(`ADDR_EBUS_LO);
    apbRead(`ADDR_EBUS_HI);
    for (int c = 0; c < 'h40; c += 'h0B) checkCode(c);

    // every register of every source is read through a code only its owner answers
    for (int n = 0; n < `NUM_SOURCES; n++) begin
      for (int r = 0; r < `SRC_REGS; r++) begin
        loadReg(n, r, randomWord());
        checkCode(n * 'h10 + r);
      end
    end

    // overlap between APR and CON and then codes nobody answers
    for (int c = 'h08; c < 'h18; c++) checkCode(c);
    checkCode('h18);
    checkCode('h2F);
    checkCode('h3C);
    checkCode('h7F);

    // rejected transfers must not disturb any later readback
    // a misdecoded write here would land in APR register 0 and code 00 reads it
    checkCode('h00);
    apbWrite(`ADDR_EBUS_LO, $urandom());
    apbWrite(`ADDR_EBUS_HI, $urandom());
    apbWrite('h010, $urandom());
    apbWrite('h180, $urandom());
    apbWrite('h102, $urandom());
    apbWrite('h110, $urandom());
    apbRead(`ADDR_DIAG);
    apbRead(`ADDR_EXT);
    apbRead(srcAddr(1, 2));
    apbRead('h7F0);
    apbRead(`ADDR_EBUS_HI);
    apbRead(`ADDR_EBUS_LO);
    apbRead(`ADDR_EBUS_HI);

    repeat (100) begin
      case ($urandom_range(0, 4))
        0: apbWrite(`ADDR_EXT, $urandom());
        1: apbWrite(srcAddr($urandom_range(0, 3), $urandom_range(0, 3)), $urandom());
        2: apbWrite(`ADDR_DIAG, $urandom_range(0, 'h3F));
        3: loadReg($urandom_range(0, 3), $urandom_range(0, 3), randomWord());
        default: begin
          addr = apbAddrT'($urandom()) & 12'hFFC;
          if ($urandom_range(0, 1)) apbWrite(addr, $urandom());
          else apbRead(addr);
        end
      endcase
      apbRead(`ADDR_EBUS_LO);
      apbRead(`ADDR_EBUS_HI);
    end

    repeat (4) @(posedge clk);
    if (u_ebusTop.u_chk.errCount == 0 && expErr.size() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("bus checker errors or unchecked transfers at the end of the run");
      abortRun();
    end
  end

endmodule

// ==== sources.f ====
+incdir+src
src/ebusPkg.sv
src/apbPkg.sv
src/apbEbusPort.sv
src/ebusSource.sv
src/ebusMux.sv
src/ebusTop.sv
tests/tbClock.sv
tests/ebusTop_chk.sv
tests/ebusTop_tb.sv

// ==== Bender.yml ====
package:
  name: ebus_diag

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/ebusPkg.sv
      - src/apbPkg.sv
      - src/apbEbusPort.sv
      - src/ebusSource.sv
      - src/ebusMux.sv
      - src/ebusTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/tbClock.sv
      - tests/ebusTop_chk.sv
      - tests/ebusTop_tb.sv
